/* sources.f */
rtl/pix_pkg.sv
rtl/pix_stream_if.sv
rtl/pix_frame_gate.sv
rtl/pix_fifo.sv
rtl/frame_store.sv
rtl/pix_controller.sv
test/tb_pix_controller.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the pixel capture controller testbench with Verilator.
# The exit status follows the simulator, nonzero when the testbench fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal \
    --top-module tb_pix_controller \
    -f sources.f \
    -Mdir obj_dir \
    && ./obj_dir/Vtb_pix_controller \
    || { echo "Simulation did not pass"; exit 1; }

echo "Simulation finished"

/* test/tb_pix_controller.sv */
`timescale 1ns/1ps

module tb_pix_controller
    import pix_pkg::*;
();

    localparam int ROWS        = 8;
    localparam int COLS        = 8;
    // Six tests, each well inside 400 cycles
    localparam int CYCLE_LIMIT = 6 * 400;

    logic       clk;
    logic       fifo_rst;
    logic [1:0] cmd;
    block_idx_t cmd_block;
    logic       capture_done;
    logic       capture_pixel_dropped;
    logic       readout_valid;
    logic       readout_ready;
    ram_word_t  readout_data;
    logic       readout_done;
    pix_data_t  pix_d;
    logic       pix_fv;
    logic       pix_lv;

    integer     seed;
    int         ready_rnd;
    logic       rand_ready;
    int         cycle_cnt    = 0;
    int         cap_done_cnt = 0;
    int         rd_done_cnt  = 0;
    int         exp_block;
    int         exp_index;
    string      cur_test;
    ram_word_t  got_q [$];
    // Pixels sent to the sensor port, per target block
    pix_data_t  pix_ref [NUM_BLOCKS][IMAGE_SIZE];

    pix_controller pix_controller_i (
        .clk                   (clk),
        .fifo_rst              (fifo_rst),
        .cmd                   (cmd),
        .cmd_block             (cmd_block),
        .capture_done          (capture_done),
        .capture_pixel_dropped (capture_pixel_dropped),
        .readout_valid         (readout_valid),
        .readout_ready         (readout_ready),
        .readout_data          (readout_data),
        .readout_done          (readout_done),
        .pix_d                 (pix_d),
        .pix_fv                (pix_fv),
        .pix_lv                (pix_lv)
    );

    initial begin
        clk = 1'b0;
    end

    always #2 clk = ~clk;

    // ====================
    // Reference and check
    // ====================
    function automatic ram_word_t expected_word(input int blk, input int idx);
        return {{(WORD_W - PIX_W){1'b0}}, pix_ref[blk][idx]};
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERR %s: expected %0h, actual %0h", name, expected, actual);
            $display("FAIL: see errors above");
            $fatal(1, "value mismatch");
        end
    endtask

    // ====================
    // Monitors
    // ====================
    // Sampled at the falling edge, where DUT outputs and ready are settled
    always @(negedge clk) begin
        if (readout_valid && readout_ready) begin
            got_q.push_back(readout_data);
        end
        if (capture_done) begin
            cap_done_cnt <= cap_done_cnt + 1;
        end
        if (readout_done) begin
            rd_done_cnt <= rd_done_cnt + 1;
        end
    end

    always @(negedge clk) begin
        if (got_q.size() > 0) begin
            check($sformatf("%s word %0d", cur_test, exp_index),
                  expected_word(exp_block, exp_index), got_q.pop_front());
            exp_index++;
        end
    end

    // Readout back-pressure, random only when asked for
    always @(posedge clk) begin
        #1;
        if (rand_ready) begin
            ready_rnd     = $random(seed);
            readout_ready = ready_rnd[0];
        end else begin
            readout_ready = 1'b1;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == CYCLE_LIMIT) begin
            $display("Timeout: the run hung, no done pulse after %0d cycles", cycle_cnt);
            $display("FAIL: see errors above");
            $fatal(1, "watchdog expired");
        end
    end

    // ====================
    // Stimulus tasks
    // ====================
    task automatic issue_cmd(input pix_cmd_e c, input int blk);
        @(posedge clk);
        #1;
        cmd       = c;
        cmd_block = block_idx_t'(blk);
        @(posedge clk);
        #1;
        cmd = CMD_NONE;
    endtask

    task automatic sensor_cycle(input logic fv, input logic lv, input pix_data_t d);
        @(posedge clk);
        #1;
        pix_fv = fv;
        pix_lv = lv;
        pix_d  = d;
    endtask

    // Sensor frame; blk below zero means the pixels are not recorded
    task automatic send_frame(input int rows, input int cols, input int blk);
        int        rnd;
        pix_data_t p;
        // Frame-valid leads the first line by one cycle
        sensor_cycle(1'b1, 1'b0, '0);
        for (int r = 0; r < rows; r++) begin
            for (int c = 0; c < cols; c++) begin
                rnd = $random(seed) & 32'h0fff;
                p   = rnd[PIX_W-1:0];
                if (blk >= 0) begin
                    pix_ref[blk][r*cols + c] = p;
                end
                sensor_cycle(1'b1, 1'b1, p);
            end
            if (r != rows - 1) begin
                sensor_cycle(1'b1, 1'b0, '0);
            end
        end
        // Frame-valid drops right behind the last pixel
        sensor_cycle(1'b0, 1'b0, '0);
        sensor_cycle(1'b0, 1'b0, '0);
    endtask

    task automatic capture_frame(input int blk, input string name);
        int start;
        start    = cap_done_cnt;
        cur_test = name;
        issue_cmd(CMD_CAPTURE, blk);
        repeat (3) @(posedge clk);
        @(negedge clk);
        check({name, " dropped after arm"}, 0, capture_pixel_dropped);
        send_frame(ROWS, COLS, blk);
        while (cap_done_cnt == start) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        check({name, " done pulses"}, start + 1, cap_done_cnt);
        check({name, " dropped"}, 0, capture_pixel_dropped);
    endtask

    task automatic read_block(input int blk, input string name);
        int start;
        start     = rd_done_cnt;
        cur_test  = name;
        exp_block = blk;
        exp_index = 0;
        got_q.delete();
        issue_cmd(CMD_READOUT, blk);
        while (rd_done_cnt == start) begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk);
        check({name, " word count"}, IMAGE_SIZE, exp_index);
        check({name, " done pulses"}, start + 1, rd_done_cnt);
    endtask

    // ====================
    // Tests
    // ====================
    initial begin
        int start;
        seed          = 82;
        rand_ready    = 1'b0;
        fifo_rst      = 1'b0;
        cmd           = CMD_NONE;
        cmd_block     = '0;
        readout_ready = 1'b1;
        pix_d         = '0;
        pix_fv        = 1'b0;
        pix_lv        = 1'b0;
        exp_block     = 0;
        exp_index     = 0;
        cur_test      = "reset";
        repeat (5) @(posedge clk);
        #1;
        fifo_rst = 1'b1;

        @(negedge clk);
        check("reset capture_done", 0, capture_done);
        check("reset readout_valid", 0, readout_valid);
        check("reset readout_done", 0, readout_done);
        check("reset dropped", 0, capture_pixel_dropped);

        capture_frame(1, "capture block 1");
        read_block(1, "readout block 1");

        capture_frame(2, "capture block 2");
        read_block(1, "recheck block 1");
        read_block(2, "readout block 2");

        rand_ready = 1'b1;
        read_block(2, "random ready block 2");
        rand_ready = 1'b0;

        // Arm in the middle of a frame, only the following frame counts
        cur_test = "mid-frame arm";
        start    = cap_done_cnt;
        fork
            send_frame(ROWS, COLS, -1);
            begin
                repeat (20) @(posedge clk);
                issue_cmd(CMD_CAPTURE, 0);
            end
        join
        send_frame(ROWS, COLS, 0);
        while (cap_done_cnt == start) begin
            @(negedge clk);
        end
        read_block(0, "mid-frame arm readout");

        // Stop returns the front end to idle, so the frame is ignored
        cur_test = "stop";
        start    = cap_done_cnt;
        issue_cmd(CMD_CAPTURE, 3);
        repeat (3) @(posedge clk);
        issue_cmd(CMD_STOP, 0);
        send_frame(ROWS, COLS, -1);
        repeat (10) @(negedge clk);
        check("stop capture_done", start, cap_done_cnt);
        check("stop dropped", 0, capture_pixel_dropped);

        // Readout takes the store away from an armed capture
        issue_cmd(CMD_CAPTURE, 3);
        repeat (3) @(posedge clk);
        fork
            read_block(1, "readout over capture");
            send_frame(ROWS, COLS, -1);
        join
        repeat (4) @(negedge clk);
        check("stalled frame dropped", 1, capture_pixel_dropped);
        check("stalled frame capture_done", start, cap_done_cnt);

        capture_frame(3, "recapture block 3");
        read_block(3, "readout block 3");

        $display("PASS: all tests");
        $finish;
    end

endmodule

/* rtl/pix_controller.sv */
`timescale 1ns/1ps

module pix_controller
    import pix_pkg::*;
(
    input  logic       clk,
    input  logic       fifo_rst,

    // Command port
    input  logic [1:0] cmd,
    input  block_idx_t cmd_block,

    // Capture status
    output logic       capture_done,
    output logic       capture_pixel_dropped,

    // Readout stream
    output logic       readout_valid,
    input  logic       readout_ready,
    output ram_word_t  readout_data,
    output logic       readout_done,

    // Sensor pins
    input  pix_data_t  pix_d,
    input  logic       pix_fv,
    input  logic       pix_lv
);

    logic capture_arm;
    logic capture_abort;

    pix_stream_if gate_to_fifo ();
    pix_stream_if fifo_to_store ();

    // ====================
    // Pipeline
    // ====================
    pix_frame_gate frame_gate_i (
        .clk           (clk),
        .fifo_rst      (fifo_rst),
        .pix_d         (pix_d),
        .pix_fv        (pix_fv),
        .pix_lv        (pix_lv),
        .capture_arm   (capture_arm),
        .capture_abort (capture_abort),
        .pixel_dropped (capture_pixel_dropped),
        .out_s         (gate_to_fifo.source)
    );

    pix_fifo fifo_i (
        .clk         (clk),
        .fifo_rst    (fifo_rst),
        .capture_arm (capture_arm),
        .in_s        (gate_to_fifo.sink),
        .out_s       (fifo_to_store.source)
    );

    frame_store frame_store_i (
        .clk           (clk),
        .fifo_rst      (fifo_rst),
        .cmd           (pix_cmd_e'(cmd)),
        .cmd_block     (cmd_block),
        .in_s          (fifo_to_store.sink),
        .capture_arm   (capture_arm),
        .capture_abort (capture_abort),
        .capture_done  (capture_done),
        .readout_valid (readout_valid),
        .readout_ready (readout_ready),
        .readout_data  (readout_data),
        .readout_done  (readout_done)
    );

endmodule

/* rtl/frame_store.sv */
`timescale 1ns/1ps

module frame_store
    import pix_pkg::*;
(
    input  logic       clk,
    input  logic       fifo_rst,
    input  pix_cmd_e   cmd,
    input  block_idx_t cmd_block,
    pix_stream_if.sink in_s,
    output logic       capture_arm,
    output logic       capture_abort,
    output logic       capture_done,
    output logic       readout_valid,
    input  logic       readout_ready,
    output ram_word_t  readout_data,
    output logic       readout_done
);

    store_state_e state;
    block_idx_t   blk;
    pix_idx_t     wr_idx;
    pix_idx_t     rd_idx;
    pix_idx_t     rd_idx_nxt;
    ram_addr_t    wr_addr;
    ram_addr_t    rd_addr;
    ram_word_t    mem [NUM_BLOCKS*IMAGE_SIZE];
    ram_word_t    ram_q;
    logic         ram_ok;
    logic         wr_en;
    logic         out_take;

    // Not ready during the arm cycle, while the FIFO flushes stale words
    assign in_s.ready = (state == ST_CAPTURE) && !capture_arm;
    assign wr_en      = in_s.valid && in_s.ready;
    assign wr_addr    = {blk, wr_idx};

    // Output register takes the next word when it is empty or being accepted
    assign out_take   = (state == ST_READ) && ram_ok && (!readout_valid || readout_ready);
    // Read one word ahead so ram_q always holds mem at rd_idx
    assign rd_idx_nxt = out_take ? rd_idx + 1'b1 : rd_idx;
    assign rd_addr    = {blk, rd_idx_nxt};

    // ====================
    // Block memory
    // ====================
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= in_s.data;
        end
        ram_q <= mem[rd_addr];
        if (out_take) begin
            readout_data <= ram_q;
        end
    end

    // ====================
    // Control FSM
    // ====================
    always_ff @(posedge clk) begin
        if (!fifo_rst) begin
            state         <= ST_IDLE;
            blk           <= '0;
            wr_idx        <= '0;
            rd_idx        <= '0;
            ram_ok        <= 1'b0;
            capture_arm   <= 1'b0;
            capture_abort <= 1'b0;
            capture_done  <= 1'b0;
            readout_valid <= 1'b0;
            readout_done  <= 1'b0;
        end else begin
            capture_arm   <= 1'b0;
            capture_abort <= 1'b0;
            capture_done  <= 1'b0;
            readout_done  <= 1'b0;
            // Memory output is good one cycle into ST_READ
            ram_ok        <= (state == ST_READ);

            case (state)
                ST_IDLE: begin
                    // Waiting for a command
                end
                ST_CAPTURE: begin
                    if (wr_en) begin
                        wr_idx <= wr_idx + 1'b1;
                        if (wr_idx == pix_idx_t'(IMAGE_SIZE - 1)) begin
                            capture_done <= 1'b1;
                            state        <= ST_IDLE;
                        end
                    end
                end
                ST_READ: begin
                    if (out_take) begin
                        readout_valid <= 1'b1;
                        rd_idx        <= rd_idx_nxt;
                        if (rd_idx == pix_idx_t'(IMAGE_SIZE - 1)) begin
                            state <= ST_DRAIN;
                        end
                    end
                end
                ST_DRAIN: begin
                    // Final word is in the output register
                    if (readout_ready) begin
                        readout_valid <= 1'b0;
                        readout_done  <= 1'b1;
                        state         <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase

            // A new command overrides whatever is running
            case (cmd)
                CMD_CAPTURE: begin
                    state         <= ST_CAPTURE;
                    blk           <= cmd_block;
                    wr_idx        <= '0;
                    capture_arm   <= 1'b1;
                    readout_valid <= 1'b0;
                end
                CMD_READOUT: begin
                    state         <= ST_READ;
                    blk           <= cmd_block;
                    rd_idx        <= '0;
                    ram_ok        <= 1'b0;
                    readout_valid <= 1'b0;
                end
                CMD_STOP: begin
                    state         <= ST_IDLE;
                    capture_abort <= 1'b1;
                    readout_valid <= 1'b0;
                end
                default: begin
                end
            endcase
        end
    end

    // ====================
    // Checks
    // ====================
    // Front end end-of-frame must agree with the write count
    a_last_at_end: assert property (
        @(posedge clk) disable iff (!fifo_rst)
        (wr_en && in_s.last) |-> wr_idx == pix_idx_t'(IMAGE_SIZE - 1)
    );

    a_done_exclusive: assert property (
        @(posedge clk) disable iff (!fifo_rst)
        !(capture_done && readout_done)
    );

endmodule

/* rtl/pix_fifo.sv */
`timescale 1ns/1ps

module pix_fifo
    import pix_pkg::*;
(
    input  logic         clk,
    input  logic         fifo_rst,
    input  logic         capture_arm,
    pix_stream_if.sink   in_s,
    pix_stream_if.source out_s
);

    ram_word_t                     mem_data [FIFO_DEPTH];
    logic                          mem_last [FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
    // Words in memory, not counting the output register
    logic [$clog2(FIFO_DEPTH):0]   count;
    logic [$clog2(FIFO_DEPTH):0]   occupancy;
    logic                          push;
    logic                          pop;
    logic                          load;

    // The output register counts as one of the FIFO_DEPTH entries
    assign occupancy  = count + out_s.valid;
    assign in_s.ready = (occupancy != FIFO_DEPTH);
    assign push       = in_s.valid && in_s.ready;
    assign pop        = out_s.valid && out_s.ready;
    // Refill the output register when it is empty or being taken
    assign load       = (count != 0) && (!out_s.valid || out_s.ready);

    // ====================
    // Storage
    // ====================
    always_ff @(posedge clk) begin
        if (push) begin
            mem_data[wr_ptr] <= in_s.data;
            mem_last[wr_ptr] <= in_s.last;
        end
        if (load) begin
            out_s.data <= mem_data[rd_ptr];
            out_s.last <= mem_last[rd_ptr];
        end
    end

    // ====================
    // Pointers and count
    // ====================
    always_ff @(posedge clk) begin
        if (!fifo_rst || capture_arm) begin
            // Reset, or flush at the start of a capture
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            out_s.valid <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (load) begin
                rd_ptr      <= rd_ptr + 1'b1;
                out_s.valid <= 1'b1;
            end else if (pop) begin
                out_s.valid <= 1'b0;
            end
            case ({push, load})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ====================
    // Checks
    // ====================
    a_no_overflow: assert property (
        @(posedge clk) disable iff (!fifo_rst)
        occupancy <= FIFO_DEPTH
    );

    a_no_underflow: assert property (
        @(posedge clk) disable iff (!fifo_rst)
        (pop && !push && !capture_arm) |=> occupancy == $past(occupancy) - 1'b1
    );

endmodule

/* rtl/pix_frame_gate.sv */
`timescale 1ns/1ps

module pix_frame_gate
    import pix_pkg::*;
(
    input  logic         clk,
    input  logic         fifo_rst,
    input  pix_data_t    pix_d,
    input  logic         pix_fv,
    input  logic         pix_lv,
    input  logic         capture_arm,
    input  logic         capture_abort,
    output logic         pixel_dropped,
    pix_stream_if.source out_s
);

    gate_state_e state;
    pix_data_t   d_q;
    logic        fv_q;
    logic        lv_q;
    logic        frame_live;

    // ====================
    // Sensor pin register
    // ====================
    always_ff @(posedge clk) begin
        d_q <= pix_d;
    end

    always_ff @(posedge clk) begin
        if (!fifo_rst) begin
            fv_q <= 1'b0;
            lv_q <= 1'b0;
        end else begin
            fv_q <= pix_fv;
            lv_q <= pix_lv;
        end
    end

    // Frame in progress, including the edge that leaves GATE_WAIT_START
    assign frame_live = fv_q && (state == GATE_FRAME || state == GATE_WAIT_START);

    // ====================
    // Frame sync FSM
    // ====================
    always_ff @(posedge clk) begin
        if (!fifo_rst) begin
            state         <= GATE_IDLE;
            out_s.valid   <= 1'b0;
            out_s.last    <= 1'b0;
            pixel_dropped <= 1'b0;
        end else begin
            out_s.valid <= frame_live && lv_q;
            // Frame-valid already low behind this pixel, so it closes the frame
            out_s.last  <= frame_live && lv_q && !pix_fv;

            // The sensor cannot stall, a refused pixel is lost
            if (out_s.valid && !out_s.ready) begin
                pixel_dropped <= 1'b1;
            end

            case (state)
                GATE_IDLE: begin
                    // Nothing passes until armed
                end
                GATE_WAIT_INVALID: begin
                    if (!fv_q) begin
                        state <= GATE_WAIT_START;
                    end
                end
                GATE_WAIT_START: begin
                    if (fv_q) begin
                        state <= GATE_FRAME;
                    end
                end
                GATE_FRAME: begin
                    if (!fv_q) begin
                        state <= GATE_IDLE;
                    end
                end
                default: begin
                    state <= GATE_IDLE;
                end
            endcase

            if (capture_arm) begin
                state         <= GATE_WAIT_INVALID;
                pixel_dropped <= 1'b0;
                out_s.valid   <= 1'b0;
                out_s.last    <= 1'b0;
            end

            // Abort wins over everything else
            if (capture_abort) begin
                state       <= GATE_IDLE;
                out_s.valid <= 1'b0;
                out_s.last  <= 1'b0;
            end
        end
    end

    // Pixel payload, zero-extended into the stored word
    always_ff @(posedge clk) begin
        out_s.data <= ram_word_t'(d_q);
    end

    // ====================
    // Checks
    // ====================
    a_valid_in_frame: assert property (
        @(posedge clk) disable iff (!fifo_rst)
        out_s.valid |-> state == GATE_FRAME
    );

endmodule

/* rtl/pix_stream_if.sv */
`timescale 1ns/1ps

// Word stream with valid/ready, last marks the final pixel of a frame
interface pix_stream_if
    import pix_pkg::*;
();

    logic      valid;
    logic      ready;
    ram_word_t data;
    logic      last;

    modport source (
        output valid,
        output data,
        output last,
        input  ready
    );

    modport sink (
        input  valid,
        input  data,
        input  last,
        output ready
    );

endinterface

/* rtl/pix_pkg.sv */
package pix_pkg;

    // ====================
    // Sizes
    // ====================
    localparam int PIX_W      = 12;
    localparam int WORD_W     = 16;
    // 8 by 8 test image
    localparam int IMAGE_SIZE = 64;
    localparam int NUM_BLOCKS = 4;
    localparam int FIFO_DEPTH = 8;

    // ====================
    // Types
    // ====================
    typedef logic [PIX_W-1:0]                  pix_data_t;
    typedef logic [WORD_W-1:0]                 ram_word_t;
    typedef logic [$clog2(NUM_BLOCKS)-1:0]     block_idx_t;
    typedef logic [$clog2(IMAGE_SIZE)-1:0]     pix_idx_t;
    // Block index in the high bits, pixel index in the low bits
    typedef logic [$clog2(NUM_BLOCKS*IMAGE_SIZE)-1:0] ram_addr_t;

    typedef enum logic [1:0] {
        CMD_NONE    = 2'd0,
        CMD_CAPTURE = 2'd1,
        CMD_READOUT = 2'd2,
        CMD_STOP    = 2'd3
    } pix_cmd_e;

    typedef enum logic [1:0] {
        GATE_IDLE,
        GATE_WAIT_INVALID,
        GATE_WAIT_START,
        GATE_FRAME
    } gate_state_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CAPTURE,
        ST_READ,
        ST_DRAIN
    } store_state_e;

endpackage
